// ==== all.f ====
+incdir+testbench
logic/mips_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/branch_unit.sv
logic/id_ex_register.sv
logic/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f all.f --top-module tb_decode_stage \
    -o tb_decode_stage

# A failing run still leaves its log for the search below
./obj_dir/tb_decode_stage > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log
then
    echo "Simulation PASSED"
    exit 0
fi

echo "Simulation FAILED, see sim.log"
exit 1

// ==== testbench/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

////////////////////////////////////////////////////////////
// Shadow register file and random source
////////////////////////////////////////////////////////////

logic [XLEN-1:0] shadow_regs [NREGS];
logic [31:0]     lcg_state = 32'd2;

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Register 0 always reads zero
function automatic logic [XLEN-1:0] read_shadow(input logic [4:0] addr);
    return (addr == 5'd0) ? '0 : shadow_regs[addr];
endfunction

function automatic instr_t rtype(input logic [5:0] fn, input logic [4:0] rs,
                                 input logic [4:0] rt, input logic [4:0] rd);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic instr_t itype(input logic [5:0] op, input logic [4:0] rs,
                                 input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic instr_t jtype(input logic [25:0] index);
    return {OP_J, index};
endfunction

// Random fields, then one of the known or unknown encodings
function automatic instr_t random_instr();
    logic [31:0] sel;
    instr_t      ins;
    sel = next_random();
    ins = next_random();
    ins.r_fmt.opcode = OP_RTYPE;
    case (sel[31:28])
        4'd0:    ins.r_fmt.funct = FN_ADD;
        4'd1:    ins.r_fmt.funct = FN_SUB;
        4'd2:    ins.r_fmt.funct = FN_AND;
        4'd3:    ins.r_fmt.funct = FN_OR;
        4'd4:    ins.r_fmt.funct = FN_SLT;
        4'd5:    ins.r_fmt.funct = 6'b100111;
        4'd6:    ins.r_fmt.opcode = OP_ADDI;
        4'd7:    ins.r_fmt.opcode = OP_ANDI;
        4'd8:    ins.r_fmt.opcode = OP_ORI;
        4'd9:    ins.r_fmt.opcode = OP_LW;
        4'd10:   ins.r_fmt.opcode = OP_SW;
        4'd11:   ins.r_fmt.opcode = OP_BEQ;
        4'd12:   ins.r_fmt.opcode = OP_BNE;
        4'd13:   ins.r_fmt.opcode = OP_J;
        4'd14:   ins.r_fmt.opcode = 6'b001010;
        default: ins.r_fmt.opcode = 6'b111111;
    endcase
    return ins;
endfunction

////////////////////////////////////////////////////////////
// Reference decode
////////////////////////////////////////////////////////////

function automatic ctrl_t ref_ctrl(input instr_t ins);
    logic [5:0] op;
    logic [5:0] fn;
    logic       is_r;
    ctrl_t      c;
    op   = ins.r_fmt.opcode;
    fn   = ins.r_fmt.funct;
    is_r = (op == OP_RTYPE) && (fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT});
    c.reg_write  = is_r || (op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_LW});
    c.mem_read   = (op == OP_LW);
    c.mem_write  = (op == OP_SW);
    c.mem_to_reg = (op == OP_LW);
    c.alu_src    = op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_LW, OP_SW};
    c.reg_dst    = is_r;
    c.imm_zero   = op inside {OP_ANDI, OP_ORI};
    c.branch_eq  = (op == OP_BEQ);
    c.branch_ne  = (op == OP_BNE);
    c.jump       = (op == OP_J);
    if (is_r)
    begin
        c.alu_op = (fn == FN_ADD) ? ALU_ADD :
                   (fn == FN_SUB) ? ALU_SUB :
                   (fn == FN_AND) ? ALU_AND :
                   (fn == FN_OR)  ? ALU_OR  : ALU_SLT;
    end
    else
    begin
        c.alu_op = (op inside {OP_ADDI, OP_LW, OP_SW}) ? ALU_ADD :
                   (op == OP_ANDI)                     ? ALU_AND :
                   (op == OP_ORI)                      ? ALU_OR  :
                   (op inside {OP_BEQ, OP_BNE})        ? ALU_SUB : ALU_NOP;
    end
    return c;
endfunction

function automatic id_ex_t ref_decode(input if_id_t f);
    ctrl_t       c;
    id_ex_t      e;
    logic [15:0] imm;
    c   = ref_ctrl(f.instr);
    imm = f.instr.i_fmt.imm;
    e.valid    = f.valid;
    e.ctrl     = f.valid ? c : '0;
    e.rs_data  = read_shadow(f.instr.r_fmt.rs);
    e.rt_data  = read_shadow(f.instr.r_fmt.rt);
    e.imm_ext  = c.imm_zero ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    e.rs       = f.instr.r_fmt.rs;
    e.rt       = f.instr.r_fmt.rt;
    e.dest     = c.reg_dst ? f.instr.r_fmt.rd : f.instr.r_fmt.rt;
    e.pc_plus4 = f.pc_plus4;
    return e;
endfunction

// Redirect only for a live instruction outside a stall
function automatic redirect_t ref_redirect(input if_id_t f, input logic stl);
    ctrl_t     c;
    logic      same;
    redirect_t rd;
    c    = ref_ctrl(f.instr);
    same = (read_shadow(f.instr.r_fmt.rs) == read_shadow(f.instr.r_fmt.rt));
    rd   = '0;
    if (f.valid && !stl && c.jump)
    begin
        rd.taken  = 1'b1;
        rd.target = {f.pc_plus4[31:28], f.instr.j_fmt.index, 2'b00};
    end
    else if (f.valid && !stl && ((c.branch_eq && same) || (c.branch_ne && !same)))
    begin
        rd.taken  = 1'b1;
        rd.target = f.pc_plus4 + ({{16{f.instr.i_fmt.imm[15]}}, f.instr.i_fmt.imm} << 2);
    end
    return rd;
endfunction

`endif

// ==== testbench/tb_decode_stage.sv ====
`default_nettype none

module tb_decode_stage
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Around 400 cycles of tests, with margin
    localparam int TIMEOUT_CYCLES = 1000;

    logic      clk;
    logic      rst_n;
    if_id_t    if_id;
    wb_t       wb;
    logic      stall;
    logic      flush;
    id_ex_t    id_ex;
    redirect_t redirect;

    id_ex_t    exp_id_ex;
    string     test_name = "reset";
    int        checked = 0;
    int        cycle_count = 0;
    instr_t    pending[$];

    `include "tb_decode_model.svh"

    decode_stage DUT
    (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_if_id    (if_id),
        .i_wb       (wb),
        .i_stall    (stall),
        .i_flush    (flush),
        .o_id_ex    (id_ex),
        .o_redirect (redirect)
    );

    always
    begin
        #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_id_ex(input string name, input id_ex_t exp, input id_ex_t act);
        if (act !== exp)
        begin
            $display("** Error: %s id_ex expected %h actual %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "ID/EX record mismatch");
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp,
                                  input redirect_t act);
        if (act !== exp)
        begin
            $display("** Error: %s redirect expected %h actual %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "Redirect mismatch");
        end
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Run stopped");
    endtask

    // Redirect in the same cycle, ID/EX one edge after acceptance
    initial
    begin
        exp_id_ex = '0;
        wait (rst_n === 1'b1);
        forever
        begin
            @(posedge clk);
            #7;
            check_id_ex(test_name, exp_id_ex, id_ex);
            check_redirect(test_name, ref_redirect(if_id, stall), redirect);
            if (flush)
            begin
                exp_id_ex = '0;
            end
            else if (!stall)
            begin
                exp_id_ex = ref_decode(if_id);
            end
            checked++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            stop_with_failure("Timeout, the test sequence did not finish in time");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic if_id_t fetch(input instr_t ins, input logic [31:0] pc);
        return {1'b1, pc, ins};
    endfunction

    // Write-back drive also updates the shadow copy
    task automatic issue(input if_id_t f, input wb_t w, input logic stl, input logic fls);
        @(posedge clk);
        #1;
        if_id = f;
        wb    = w;
        stall = stl;
        flush = fls;
        if (w.we)
        begin
            shadow_regs[w.rd] = w.data;
        end
    endtask

    task automatic run_list(input string name, input logic [31:0] pc);
        test_name = name;
        while (pending.size() > 0)
        begin
            issue(fetch(pending.pop_front(), pc), '0, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        wb_t         w;
        if_id_t      f;
        logic [31:0] r;
        logic [31:0] s;
        int          target;
        clk         = 1'b0;
        rst_n       = 1'b0;
        if_id       = '0;
        wb          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        shadow_regs = '{default: '0};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (id_ex.valid !== 1'b0 || redirect.taken !== 1'b0)
        begin
            stop_with_failure("Outputs were not idle after reset");
        end

        test_name = "reset_state";
        for (int k = 0; k < NREGS; k++)
        begin
            issue(fetch(rtype(FN_ADD, 5'(k), 5'(NREGS - 1 - k), 5'd1), 32'h100), '0,
                  1'b0, 1'b0);
        end

        // Same cycle write and read first, then read back
        test_name = "register_write_read";
        for (int k = 1; k < NREGS; k++)
        begin
            r = next_random();
            w = {1'b1, 5'(k), r};
            issue(fetch(rtype(FN_OR, 5'(k), 5'(k - 1), 5'd2), 32'h200), w, 1'b0, 1'b0);
        end
        for (int k = 0; k < NREGS; k++)
        begin
            issue(fetch(itype(OP_SW, 5'(k), 5'((k + 7) % NREGS), 16'h0004), 32'h300), '0,
                  1'b0, 1'b0);
        end
        w = {1'b1, 5'd0, 32'hDEADBEEF};
        issue(fetch(rtype(FN_ADD, 5'd0, 5'd0, 5'd3), 32'h400), w, 1'b0, 1'b0);

        pending = '{rtype(FN_ADD, 5'd3, 5'd4, 5'd5), rtype(FN_SUB, 5'd3, 5'd4, 5'd5),
                    rtype(FN_AND, 5'd3, 5'd4, 5'd5), rtype(FN_OR, 5'd3, 5'd4, 5'd5),
                    rtype(FN_SLT, 5'd3, 5'd4, 5'd5), rtype(6'b100111, 5'd3, 5'd4, 5'd5),
                    itype(OP_ADDI, 5'd6, 5'd7, 16'h0010), itype(OP_ANDI, 5'd6, 5'd7, 16'h0010),
                    itype(OP_ORI, 5'd6, 5'd7, 16'h0010), itype(OP_LW, 5'd6, 5'd7, 16'h0010),
                    itype(OP_SW, 5'd6, 5'd7, 16'h0010), itype(OP_BEQ, 5'd6, 5'd7, 16'h0010),
                    itype(OP_BNE, 5'd6, 5'd7, 16'h0010), jtype(26'h0000040),
                    itype(6'b001010, 5'd6, 5'd7, 16'h0010), itype(6'b111111, 5'd6, 5'd7, 16'h0)};
        run_list("control_decode", 32'h0000_1000);

        pending = '{itype(OP_ADDI, 5'd1, 5'd2, 16'h8001), itype(OP_LW, 5'd1, 5'd2, 16'h8001),
                    itype(OP_SW, 5'd1, 5'd2, 16'h8001), itype(OP_ANDI, 5'd1, 5'd2, 16'hFFFC),
                    itype(OP_ORI, 5'd1, 5'd2, 16'hFFFC), rtype(FN_SUB, 5'd1, 5'd2, 5'd9)};
        run_list("immediate_destination", 32'h0000_2000);

        pending = '{itype(OP_BEQ, 5'd8, 5'd8, 16'h0010), itype(OP_BEQ, 5'd8, 5'd9, 16'h0010),
                    itype(OP_BNE, 5'd8, 5'd8, 16'h0010), itype(OP_BNE, 5'd8, 5'd9, 16'h0010),
                    itype(OP_BEQ, 5'd0, 5'd0, 16'hFFF0), jtype(26'h3FFFFFF)};
        run_list("branch_jump", 32'hA000_0040);
        issue({1'b0, 32'h600, itype(OP_BEQ, 5'd8, 5'd8, 16'h0010)}, '0, 1'b0, 1'b0);
        issue({1'b0, 32'h604, jtype(26'h0000100)}, '0, 1'b0, 1'b0);

        // Taken branch held in a stall, then flushes with and without stall
        test_name = "stall_flush";
        issue(fetch(itype(OP_ADDI, 5'd10, 5'd11, 16'h1234), 32'h500), '0, 1'b0, 1'b0);
        repeat (3)
        begin
            issue(fetch(itype(OP_BEQ, 5'd12, 5'd12, 16'h0008), 32'h504), '0, 1'b1, 1'b0);
        end
        issue(fetch(itype(OP_BEQ, 5'd12, 5'd12, 16'h0008), 32'h504), '0, 1'b1, 1'b1);
        issue(fetch(rtype(FN_SUB, 5'd13, 5'd14, 5'd15), 32'h508), '0, 1'b0, 1'b0);
        issue(fetch(itype(OP_LW, 5'd16, 5'd17, 16'h0020), 32'h50C), '0, 1'b0, 1'b1);
        issue(fetch(jtype(26'h0000200), 32'h510), '0, 1'b0, 1'b0);

        test_name = "random";
        for (int n = 0; n < 200; n++)
        begin
            r          = next_random();
            s          = next_random();
            w.we       = r[31];
            w.rd       = r[30:26];
            w.data     = next_random();
            f.valid    = (r[25:23] != 3'd0);
            f.pc_plus4 = {s[31:2], 2'b00};
            f.instr    = random_instr();
            issue(f, w, r[22:20] == 3'd0, r[19:16] == 4'd0);
        end

        // Last record is checked one edge later
        target = checked + 2;
        wait (checked >= target);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    // From fetch
    input  if_id_t    i_if_id,
    // From write-back
    input  wb_t       i_wb,
    // From hazard logic
    input  wire       i_stall,
    input  wire       i_flush,
    // To execute
    output id_ex_t    o_id_ex,
    // To fetch, same cycle
    output redirect_t o_redirect
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic            active;

    // Only a live, unstalled instruction may redirect fetch
    assign active = i_if_id.valid & ~i_stall;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    control_unit u_control_unit
    (
        .i_instr    (i_if_id.instr),
        .o_ctrl     (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////////////////////////

    register_file u_register_file
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .i_rs_addr  (i_if_id.instr.r_fmt.rs),
        .i_rt_addr  (i_if_id.instr.r_fmt.rt),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data)
    );

    ////////////////////////////////////////////////////////////
    // Branch and jump resolution
    ////////////////////////////////////////////////////////////

    branch_unit u_branch_unit
    (
        .i_instr    (i_if_id.instr),
        .i_pc_plus4 (i_if_id.pc_plus4),
        .i_ctrl     (ctrl),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .i_active   (active),
        .o_redirect (o_redirect)
    );

    ////////////////////////////////////////////////////////////
    // ID/EX record
    ////////////////////////////////////////////////////////////

    id_ex_register u_id_ex_register
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_if_id    (i_if_id),
        .i_ctrl     (ctrl),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_id_ex    (o_id_ex)
    );

endmodule

`default_nettype wire

// ==== logic/id_ex_register.sv ====
`default_nettype none

module id_ex_register
    import mips_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_stall,
    input  wire             i_flush,
    input  if_id_t          i_if_id,
    input  ctrl_t           i_ctrl,
    input  wire  [XLEN-1:0] i_rs_data,
    input  wire  [XLEN-1:0] i_rt_data,
    output id_ex_t          o_id_ex
);

    id_ex_t          next_rec;
    id_ex_t          rec;
    logic [15:0]     imm;
    logic [XLEN-1:0] imm_ext;

    assign imm = i_if_id.instr.i_fmt.imm;

    ////////////////////////////////////////////////////////////
    // Next record
    ////////////////////////////////////////////////////////////

    // andi and ori zero-extend, everything else sign-extends
    assign imm_ext = i_ctrl.imm_zero ? {{(XLEN-16){1'b0}}, imm}
                                     : {{(XLEN-16){imm[15]}}, imm};

    always_comb
    begin
        next_rec          = '0;
        next_rec.valid    = i_if_id.valid;
        next_rec.ctrl     = i_if_id.valid ? i_ctrl : '0;
        next_rec.rs_data  = i_rs_data;
        next_rec.rt_data  = i_rt_data;
        next_rec.imm_ext  = imm_ext;
        next_rec.rs       = i_if_id.instr.r_fmt.rs;
        next_rec.rt       = i_if_id.instr.r_fmt.rt;
        // R-type writes rd, I-type writes rt
        next_rec.dest     = i_ctrl.reg_dst ? i_if_id.instr.r_fmt.rd
                                           : i_if_id.instr.r_fmt.rt;
        next_rec.pc_plus4 = i_if_id.pc_plus4;
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////

    // Flush wins over stall and loads a bubble
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rec <= '0;
        end
        else if (i_flush)
        begin
            rec <= '0;
        end
        else if (!i_stall)
        begin
            rec <= next_rec;
        end
    end

    assign o_id_ex = rec;

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`default_nettype none

module branch_unit
    import mips_pkg::*;
(
    input  instr_t          i_instr,
    input  wire  [XLEN-1:0] i_pc_plus4,
    input  ctrl_t           i_ctrl,
    input  wire  [XLEN-1:0] i_rs_data,
    input  wire  [XLEN-1:0] i_rt_data,
    // Valid and not stalled
    input  wire             i_active,
    output redirect_t       o_redirect
);

    logic            operands_eq;
    logic            take_branch;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jump_target;

    assign operands_eq = (i_rs_data == i_rt_data);

    ////////////////////////////////////////////////////////////
    // Targets
    ////////////////////////////////////////////////////////////

    // Word offset relative to PC+4
    assign branch_target = i_pc_plus4 +
        {{(XLEN-18){i_instr.i_fmt.imm[15]}}, i_instr.i_fmt.imm, 2'b00};

    // Region of PC+4 with the word index
    assign jump_target = {i_pc_plus4[XLEN-1:XLEN-4], i_instr.j_fmt.index, 2'b00};

    ////////////////////////////////////////////////////////////
    // Decision
    ////////////////////////////////////////////////////////////

    assign take_branch = i_active &&
        (i_ctrl.jump ||
         (i_ctrl.branch_eq && operands_eq) ||
         (i_ctrl.branch_ne && !operands_eq));

    always_comb
    begin
        o_redirect = '0;
        if (take_branch)
        begin
            o_redirect.taken  = 1'b1;
            o_redirect.target = i_ctrl.jump ? jump_target : branch_target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wb_t                        i_wb,
    input  wire  [$clog2(NREGS)-1:0]   i_rs_addr,
    input  wire  [$clog2(NREGS)-1:0]   i_rt_addr,
    output logic [XLEN-1:0]            o_rs_data,
    output logic [XLEN-1:0]            o_rt_data
);

    logic [XLEN-1:0] regs [NREGS];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // Falling edge write, so the same cycle's read sees new data
    always_ff @(negedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb.we && (i_wb.rd != '0))
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Register 0 is hardwired to zero
    always_comb
    begin
        o_rs_data = regs[i_rs_addr];
        o_rt_data = regs[i_rt_addr];
        if (i_rs_addr == '0)
        begin
            o_rs_data = '0;
        end
        if (i_rt_addr == '0)
        begin
            o_rt_data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/control_unit.sv ====
`default_nettype none

module control_unit
    import mips_pkg::*;
(
    input  instr_t i_instr,
    output ctrl_t  o_ctrl
);

    ctrl_t ctrl;

    always_comb
    begin
        // Bubble unless a known encoding matches
        ctrl = '0;

        case (i_instr.r_fmt.opcode)
            OP_RTYPE:
            begin
                case (i_instr.r_fmt.funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_OR:  ctrl.alu_op = ALU_OR;
                    FN_SLT: ctrl.alu_op = ALU_SLT;
                    default: ctrl.alu_op = ALU_NOP;
                endcase
                // Unknown funct stays a bubble
                if (ctrl.alu_op != ALU_NOP)
                begin
                    ctrl.reg_write = 1'b1;
                    ctrl.reg_dst   = 1'b1;
                end
            end

            OP_ADDI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end

            // Logical immediates take the zero-extended form
            OP_ANDI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_zero  = 1'b1;
                ctrl.alu_op    = ALU_AND;
            end

            OP_ORI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_zero  = 1'b1;
                ctrl.alu_op    = ALU_OR;
            end

            // Address is base plus offset
            OP_LW:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
            end

            OP_SW:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end

            OP_BEQ:
            begin
                ctrl.branch_eq = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end

            OP_BNE:
            begin
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end

            OP_J:    ctrl.jump = 1'b1;

            default: ctrl = '0;
        endcase
    end

    assign o_ctrl = ctrl;

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int NREGS = 32;
    localparam int XLEN  = 32;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // Function field of R-type
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;
    localparam logic [5:0] FN_SLT = 6'b101010;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Instruction word in its three formats
    ////////////////////////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } j_fmt;
    } instr_t;

    ////////////////////////////////////////////////////////////
    // Pipeline records
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        logic    reg_dst;
        logic    imm_zero;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_plus4;
        instr_t          instr;
    } if_id_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [XLEN-1:0] rs_data;
        logic [XLEN-1:0] rt_data;
        logic [XLEN-1:0] imm_ext;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      dest;
        logic [XLEN-1:0] pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire
